// ==== Bender.yml ====
package:
  name: camd_mem

sources:
  - include_dirs:
      - common
    files:
      - common/camd_pkg.sv
      - src/camd_arbiter.sv
      - camd_ram/camd_ram.sv
      - camd_ram/camd_resp_router.sv
      - src/camd_mem_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/camd_mem_tb.sv

// ==== camd_ram/camd_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "camd_config.svh"

module camd_ram (
   input  wire                       clk,
   input  wire                       i_rst,
   // Granted command.
   input  wire  [`CAMD_ADDR_W-1:0]   i_adr,
   input  camd_pkg::cmd_e            i_cmd,
   input  wire  [`CAMD_DATA_W-1:0]   i_dat,
   input  wire  [`CAMD_MSK_W-1:0]    i_msk,
   input  wire                       i_vld,
   input  camd_pkg::port_e           i_tag,
   output logic                      o_rdy,
   // Read beat.
   output logic [`CAMD_DATA_W-1:0]   o_rd_dat,
   output logic                      o_rd_vld,
   output camd_pkg::port_e           o_rd_tag,
   input  wire                       i_rd_rdy
);

   localparam int WADR_W = $clog2(`CAMD_DEPTH);
   localparam int BYTE_W = `CAMD_DATA_W / `CAMD_MSK_W;

   logic [`CAMD_DATA_W-1:0] mem [`CAMD_DEPTH];

   logic [WADR_W-1:0]       word_adr;
   logic [`CAMD_DATA_W-1:0] rd_word;
   logic                    accept;
   logic                    rd_acc;
   logic                    wr_acc;

   // Output stage and the one-entry hold behind it.
   logic                    out_vld;
   logic [`CAMD_DATA_W-1:0] out_dat;
   camd_pkg::port_e         out_tag;
   logic                    hold_vld;
   logic [`CAMD_DATA_W-1:0] hold_dat;
   camd_pkg::port_e         hold_tag;
   logic                    load_out;
   logic                    hold_nxt;
   logic                    rdy_q;

   assign word_adr = i_adr[WADR_W+1:2];  // Byte address to word index.
   assign rd_word  = mem[word_adr];

   assign accept = i_vld & o_rdy;
   assign rd_acc = accept & (i_cmd == camd_pkg::CMD_READ);
   assign wr_acc = accept & (i_cmd == camd_pkg::CMD_WRITE);

   // Output stage can take a beat when empty or when its beat leaves now.
   assign load_out = ~out_vld | i_rd_rdy;

   always_comb begin
      if (load_out) begin
         hold_nxt = hold_vld & rd_acc;
      end else begin
         hold_nxt = hold_vld | rd_acc;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_acc) begin
         for (int b = 0; b < `CAMD_MSK_W; b++) begin
            if (i_msk[b]) begin
               mem[word_adr][b*BYTE_W +: BYTE_W] <= i_dat[b*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         out_vld  <= 1'b0;
         hold_vld <= 1'b0;
         rdy_q    <= 1'b0;
      end else begin
         if (load_out) begin
            out_vld <= hold_vld | rd_acc;
         end
         hold_vld <= hold_nxt;
         rdy_q    <= ~hold_nxt;  // Ready drops once the hold entry is taken.
      end
   end

   always_ff @(posedge clk) begin
      if (load_out) begin
         if (hold_vld) begin
            out_dat <= hold_dat;  // Older beat moves up first.
            out_tag <= hold_tag;
            if (rd_acc) begin
               hold_dat <= rd_word;
               hold_tag <= i_tag;
            end
         end else if (rd_acc) begin
            out_dat <= rd_word;
            out_tag <= i_tag;
         end
      end else if (rd_acc) begin
         hold_dat <= rd_word;
         hold_tag <= i_tag;
      end
   end

   assign o_rdy    = rdy_q;
   assign o_rd_vld = out_vld;
   assign o_rd_dat = out_dat;
   assign o_rd_tag = out_tag;

endmodule

`default_nettype wire

// ==== camd_ram/camd_resp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "camd_config.svh"

module camd_resp_router (
   input  wire                       clk,
   input  wire                       i_rst,
   // One push per accepted read.
   input  wire                       i_push,
   input  camd_pkg::port_e           i_push_tag,
   output logic                      o_space,
   // Read beat from the RAM.
   input  wire  [`CAMD_DATA_W-1:0]   i_rd_dat,
   input  wire                       i_rd_vld,
   input  camd_pkg::port_e           i_rd_tag,
   output logic                      o_rd_rdy,
   // Instruction port read channel.
   output logic [`CAMD_DATA_W-1:0]   o_i_rd_dat,
   output logic                      o_i_rd_vld,
   input  wire                       i_i_rd_rdy,
   // Data port read channel.
   output logic [`CAMD_DATA_W-1:0]   o_d_rd_dat,
   output logic                      o_d_rd_vld,
   input  wire                       i_d_rd_rdy
);

   localparam int CNT_W = $clog2(`CAMD_RQ_DEPTH + 1);

   logic [CNT_W-1:0] cnt;
   logic             pop;
   logic             to_i;
   logic             push_rd;

   // Reads for either port share one budget of outstanding slots.
   assign push_rd = i_push;

   assign to_i = (i_rd_tag == camd_pkg::PORT_I);
   assign pop  = i_rd_vld & o_rd_rdy;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         cnt <= '0;
      end else if (push_rd & ~pop) begin
         cnt <= cnt + 1'b1;
      end else if (pop & ~push_rd) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign o_space = (cnt < CNT_W'(`CAMD_RQ_DEPTH));

   // Beats leave in grant order, so a stalled port holds up the other one.
   assign o_i_rd_vld = i_rd_vld & to_i;
   assign o_d_rd_vld = i_rd_vld & ~to_i;
   assign o_i_rd_dat = i_rd_dat;
   assign o_d_rd_dat = i_rd_dat;
   assign o_rd_rdy   = to_i ? i_i_rd_rdy : i_d_rd_rdy;

endmodule

`default_nettype wire

// ==== common/camd_config.svh ====
`ifndef CAMD_CONFIG_SVH
`define CAMD_CONFIG_SVH

// Byte address width on both requester ports.
`define CAMD_ADDR_W 32

// Data word width and its byte mask.
`define CAMD_DATA_W 32
`define CAMD_MSK_W 4

// Number of words in the RAM.
`define CAMD_DEPTH 1024

// Reads allowed in flight between grant and delivery.
`define CAMD_RQ_DEPTH 4

`endif

// ==== common/camd_pkg.sv ====
`default_nettype none

package camd_pkg;

   // Data-port command bit as carried on the ca channel.
   typedef enum logic {
      CMD_READ  = 1'b0,
      CMD_WRITE = 1'b1
   } cmd_e;

   // Owner of a granted command and of the read beat it later produces.
   typedef enum logic {
      PORT_I = 1'b0,
      PORT_D = 1'b1
   } port_e;

endpackage

`default_nettype wire

// ==== sim/camd_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "camd_config.svh"

module camd_mem_tb;

   logic                    clk;
   logic                    i_rst;
   logic [`CAMD_ADDR_W-1:0] i_i_ca_adr;
   logic                    i_i_ca_vld;
   wire                     o_i_ca_rdy;
   wire  [`CAMD_DATA_W-1:0] o_i_rd_dat;
   wire                     o_i_rd_vld;
   logic                    i_i_rd_rdy;
   camd_pkg::cmd_e          i_d_ca_cmd;
   logic [`CAMD_ADDR_W-1:0] i_d_ca_adr;
   logic                    i_d_ca_vld;
   wire                     o_d_ca_rdy;
   logic [`CAMD_DATA_W-1:0] i_d_dm_dat;
   logic [`CAMD_MSK_W-1:0]  i_d_dm_msk;
   logic                    i_d_dm_vld;
   wire                     o_d_dm_rdy;
   wire  [`CAMD_DATA_W-1:0] o_d_rd_dat;
   wire                     o_d_rd_vld;
   logic                    i_d_rd_rdy;

   logic [`CAMD_DATA_W-1:0] shadow [16];  // Only the first 16 words are used.
   logic [`CAMD_DATA_W-1:0] exp_i [$];
   logic [`CAMD_DATA_W-1:0] exp_d [$];
   string                   tname;
   int                      errors;
   int                      err_start;
   int                      tests_run;
   int                      tests_failed;
   int                      rd_acc_cnt;
   int                      deliv_cnt;
   int                      i_skip;
   int                      d_skip;
   bit                      bp_en;

   camd_mem_top i_dut (.*);

   always #5 clk = ~clk;

   // Random back-pressure on both read channels.
   always @(negedge clk) begin
      if (bp_en) begin
         i_i_rd_rdy = $urandom % 2;
         i_d_rd_rdy = $urandom % 2;
      end
   end

   always @(posedge clk) begin
      logic [`CAMD_DATA_W-1:0] exp;
      logic                    space;
      logic                    i_elig;
      logic                    d_elig;
      if (!i_rst) begin
         space = (exp_i.size() + exp_d.size()) < `CAMD_RQ_DEPTH;  // Room for one more read.
         if (i_i_ca_vld && o_i_ca_rdy) begin
            exp_i.push_back(shadow[i_i_ca_adr[5:2]]);
            rd_acc_cnt++;
         end
         if (i_d_ca_vld && o_d_ca_rdy) begin
            if (i_d_ca_cmd == camd_pkg::CMD_WRITE) begin
               for (int b = 0; b < `CAMD_MSK_W; b++) begin
                  if (i_d_dm_msk[b]) begin
                     shadow[i_d_ca_adr[5:2]][b*8 +: 8] = i_d_dm_dat[b*8 +: 8];
                  end
               end
            end else begin
               exp_d.push_back(shadow[i_d_ca_adr[5:2]]);
               rd_acc_cnt++;
            end
         end
         if (o_i_rd_vld && i_i_rd_rdy) begin
            deliv_cnt++;
            if (exp_i.size() == 0) begin
               $display("ERROR: %s instruction beat arrived with no read outstanding", tname);
               errors++;
            end else begin
               exp = exp_i.pop_front();
               assert (o_i_rd_dat === exp) else begin
                  $display("MISMATCH %s i_rd_dat expected %h actual %h", tname, exp, o_i_rd_dat);
                  errors++;
               end
            end
         end
         if (o_d_rd_vld && i_d_rd_rdy) begin
            deliv_cnt++;
            if (exp_d.size() == 0) begin
               $display("ERROR: %s data beat arrived with no read outstanding", tname);
               errors++;
            end else begin
               exp = exp_d.pop_front();
               assert (o_d_rd_dat === exp) else begin
                  $display("MISMATCH %s d_rd_dat expected %h actual %h", tname, exp, o_d_rd_dat);
                  errors++;
               end
            end
         end
         // A write goes in only together with its data beat.
         if (i_d_ca_vld && i_d_ca_cmd == camd_pkg::CMD_WRITE) begin
            assert (o_d_ca_rdy == o_d_dm_rdy) else begin
               $display("MISMATCH %s dm_rdy expected %b actual %b", tname, o_d_ca_rdy, o_d_dm_rdy);
               errors++;
            end
            assert (!(o_d_ca_rdy && !i_d_dm_vld)) else begin
               $display("ERROR: %s write command accepted without its data beat", tname);
               errors++;
            end
         end
         // Count grants to one port while the other stays eligible.
         i_elig = i_i_ca_vld && space;
         d_elig = i_d_ca_vld && ((i_d_ca_cmd == camd_pkg::CMD_READ) ? space : i_d_dm_vld);
         if (o_i_ca_rdy || !i_elig) i_skip = 0;
         else if (o_d_ca_rdy) i_skip++;
         if (o_d_ca_rdy || !d_elig) d_skip = 0;
         else if (o_i_ca_rdy) d_skip++;
         assert (i_skip <= 2 && d_skip <= 2) else begin
            $display("ERROR: %s a port waited through more than two grants", tname);
            errors++;
         end
      end
   end

   task automatic start_test(input string name);
      tname     = name;
      err_start = errors;
      tests_run++;
   endtask

   task automatic finish_test();
      if (errors == err_start) begin
         $display("test %s: ok", tname);
      end else begin
         $display("test %s: failed with %0d errors", tname, errors - err_start);
         tests_failed++;
      end
   endtask

   task automatic i_read(input logic [`CAMD_ADDR_W-1:0] adr, input bit chk_lat);
      int t;
      bit done;
      @(negedge clk);
      i_i_ca_adr = adr;
      i_i_ca_vld = 1'b1;
      done = 0;
      t    = 0;
      while (!done && t < 300) begin
         @(posedge clk);
         if (o_i_ca_rdy) done = 1;
         t++;
      end
      if (!done) begin
         $display("ERROR: %s instruction read was never accepted", tname);
         errors++;
      end
      @(negedge clk);
      i_i_ca_vld = 1'b0;
      if (done && chk_lat) begin
         assert (o_i_rd_vld) else begin
            $display("MISMATCH %s i_rd_vld one cycle later expected 1 actual %b", tname,
                     o_i_rd_vld);
            errors++;
         end
      end
   endtask

   // The data beat of a write is offered dm_delay cycles after the command.
   task automatic d_cmd(input camd_pkg::cmd_e cmd, input logic [`CAMD_ADDR_W-1:0] adr,
                        input logic [`CAMD_DATA_W-1:0] dat, input logic [`CAMD_MSK_W-1:0] msk,
                        input int dm_delay);
      int t;
      bit done;
      @(negedge clk);
      i_d_ca_cmd = cmd;
      i_d_ca_adr = adr;
      i_d_ca_vld = 1'b1;
      i_d_dm_dat = dat;
      i_d_dm_msk = msk;
      i_d_dm_vld = (cmd == camd_pkg::CMD_WRITE) && (dm_delay == 0);
      done = 0;
      t    = 0;
      while (!done && t < 300) begin
         @(posedge clk);
         if (o_d_ca_rdy) begin
            done = 1;
         end else begin
            @(negedge clk);
            t++;
            if (cmd == camd_pkg::CMD_WRITE && t >= dm_delay) i_d_dm_vld = 1'b1;
         end
      end
      if (!done) begin
         $display("ERROR: %s data command was never accepted", tname);
         errors++;
      end
      @(negedge clk);
      i_d_ca_vld = 1'b0;
      i_d_dm_vld = 1'b0;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while ((exp_i.size() != 0 || exp_d.size() != 0) && t < 500) begin
         @(negedge clk);
         t++;
      end
      if (exp_i.size() != 0 || exp_d.size() != 0) begin
         $display("ERROR: %s outstanding reads were never delivered", tname);
         errors++;
      end
   endtask

   function automatic logic [`CAMD_ADDR_W-1:0] rand_adr();
      return {26'd0, 4'($urandom % 16), 2'b00};
   endfunction

   function automatic camd_pkg::cmd_e rand_cmd();
      return ($urandom % 2) ? camd_pkg::CMD_WRITE : camd_pkg::CMD_READ;
   endfunction

   initial begin
      int acc0;
      int del0;
      void'($urandom(32'h9715_ad6c));
      clk = 0;
      i_rst = 1;
      bp_en = 0;
      i_i_ca_adr = '0;
      i_i_ca_vld = 1;  // Requests stay up through reset.
      i_i_rd_rdy = 1;
      i_d_ca_cmd = camd_pkg::CMD_WRITE;
      i_d_ca_adr = '0;
      i_d_ca_vld = 1;
      i_d_dm_dat = '0;
      i_d_dm_msk = '0;
      i_d_dm_vld = 1;
      i_d_rd_rdy = 1;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      rd_acc_cnt = 0;
      deliv_cnt = 0;
      i_skip = 0;
      d_skip = 0;

      start_test("reset_quiet");
      for (int c = 0; c < 20; c++) begin
         @(negedge clk);
         assert (!(o_i_ca_rdy | o_d_ca_rdy | o_d_dm_rdy | o_i_rd_vld | o_d_rd_vld)) else begin
            $display("ERROR: %s a ready or valid output is high in cycle %0d", tname, c);
            errors++;
         end
         if (c == 15) begin
            i_rst      = 0;
            i_i_ca_vld = 0;
            i_d_ca_vld = 0;
            i_d_dm_vld = 0;
            i_d_ca_cmd = camd_pkg::CMD_READ;
         end
      end
      finish_test();

      start_test("masked_write_read");
      for (int w = 0; w < 16; w++) begin
         d_cmd(camd_pkg::CMD_WRITE, 32'(w * 4), $urandom, 4'hf, 0);  // Defined contents.
      end
      repeat (30) d_cmd(camd_pkg::CMD_WRITE, rand_adr(), $urandom, 4'($urandom), 0);
      for (int w = 0; w < 16; w++) begin
         d_cmd(camd_pkg::CMD_READ, 32'(w * 4), '0, '0, 0);
      end
      wait_drain();
      finish_test();

      start_test("instruction_reads");
      repeat (20) i_read(rand_adr(), 1);
      wait_drain();
      finish_test();

      start_test("write_pairing");
      repeat (10) d_cmd(camd_pkg::CMD_WRITE, rand_adr(), $urandom, 4'($urandom),
                        1 + $urandom % 4);
      wait_drain();
      finish_test();

      start_test("concurrent_backpressure");
      bp_en = 1;
      fork
         repeat (60) i_read(rand_adr(), 0);
         repeat (60) d_cmd(rand_cmd(), rand_adr(), $urandom, 4'($urandom), $urandom % 3);
      join
      @(negedge clk);
      bp_en = 0;
      i_i_rd_rdy = 1;
      i_d_rd_rdy = 1;
      wait_drain();
      finish_test();

      start_test("outstanding_limit");
      @(negedge clk);
      i_i_rd_rdy = 0;
      i_d_rd_rdy = 0;
      acc0 = rd_acc_cnt;
      del0 = deliv_cnt;
      i_i_ca_adr = rand_adr();
      i_d_ca_adr = rand_adr();
      i_d_ca_cmd = camd_pkg::CMD_READ;
      i_i_ca_vld = 1;
      i_d_ca_vld = 1;
      repeat (20) @(negedge clk);
      assert (rd_acc_cnt - acc0 <= 4) else begin
         $display("MISMATCH %s reads accepted expected <= 4 actual %0d", tname, rd_acc_cnt - acc0);
         errors++;
      end
      assert (!o_i_ca_rdy && !o_d_ca_rdy) else begin
         $display("ERROR: %s a command ready is still high with reads stalled", tname);
         errors++;
      end
      i_i_ca_vld = 0;
      i_d_ca_vld = 0;
      i_i_rd_rdy = 1;
      i_d_rd_rdy = 1;
      wait_drain();
      assert (deliv_cnt - del0 == rd_acc_cnt - acc0) else begin
         $display("MISMATCH %s beats delivered expected %0d actual %0d", tname,
                  rd_acc_cnt - acc0, deliv_cnt - del0);
         errors++;
      end
      finish_test();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/camd_pkg.sv
src/camd_arbiter.sv
camd_ram/camd_ram.sv
camd_ram/camd_resp_router.sv
src/camd_mem_top.sv
sim/camd_mem_tb.sv

// ==== src/camd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "camd_config.svh"

module camd_arbiter (
   input  wire                       clk,
   input  wire                       i_rst,
   // Instruction command channel.
   input  wire  [`CAMD_ADDR_W-1:0]   i_i_adr,
   input  wire                       i_i_vld,
   output logic                      o_i_rdy,
   // Data command and write-data channels.
   input  camd_pkg::cmd_e            i_d_cmd,
   input  wire  [`CAMD_ADDR_W-1:0]   i_d_adr,
   input  wire                       i_d_vld,
   output logic                      o_d_rdy,
   input  wire  [`CAMD_DATA_W-1:0]   i_d_dat,
   input  wire  [`CAMD_MSK_W-1:0]    i_d_msk,
   input  wire                       i_d_dm_vld,
   output logic                      o_d_dm_rdy,
   // Granted command towards the RAM.
   output logic [`CAMD_ADDR_W-1:0]   o_m_adr,
   output camd_pkg::cmd_e            o_m_cmd,
   output logic [`CAMD_DATA_W-1:0]   o_m_dat,
   output logic [`CAMD_MSK_W-1:0]    o_m_msk,
   output logic                      o_m_vld,
   output camd_pkg::port_e           o_m_tag,
   input  wire                       i_m_rdy,
   // Response queue has room for another read.
   input  wire                       i_q_space
);

   camd_pkg::port_e last_q;
   logic            d_is_rd;
   logic            i_elig;
   logic            d_elig;
   logic            grant_i;
   logic            grant_d;
   logic            accept;

   assign d_is_rd = (i_d_cmd == camd_pkg::CMD_READ);

   // A write only competes once its data beat is present.
   assign i_elig = i_i_vld & i_q_space;
   assign d_elig = i_d_vld & (d_is_rd ? i_q_space : i_d_dm_vld);

   // The data port wins unless it was served last and the other side wants in.
   assign grant_d = d_elig & (~i_elig | (last_q == camd_pkg::PORT_I));
   assign grant_i = i_elig & ~grant_d;

   assign o_m_vld = grant_i | grant_d;
   assign o_m_tag = grant_d ? camd_pkg::PORT_D : camd_pkg::PORT_I;
   assign o_m_adr = grant_d ? i_d_adr : i_i_adr;
   assign o_m_cmd = grant_d ? i_d_cmd : camd_pkg::CMD_READ;
   assign o_m_dat = i_d_dat;  // Only looked at on a data-port write.
   assign o_m_msk = i_d_msk;

   assign accept = o_m_vld & i_m_rdy;

   assign o_i_rdy    = grant_i & i_m_rdy;
   assign o_d_rdy    = grant_d & i_m_rdy;
   assign o_d_dm_rdy = grant_d & i_m_rdy & ~d_is_rd;  // Rises with o_d_rdy on writes.

   always_ff @(posedge clk) begin
      if (i_rst) begin
         last_q <= camd_pkg::PORT_D;  // Instruction port goes first.
      end else if (accept) begin
         last_q <= o_m_tag;
      end
   end

endmodule

`default_nettype wire

// ==== src/camd_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "camd_config.svh"

module camd_mem_top (
   input  wire                       clk,
   input  wire                       i_rst,
   // Instruction port.
   input  wire  [`CAMD_ADDR_W-1:0]   i_i_ca_adr,
   input  wire                       i_i_ca_vld,
   output logic                      o_i_ca_rdy,
   output logic [`CAMD_DATA_W-1:0]   o_i_rd_dat,
   output logic                      o_i_rd_vld,
   input  wire                       i_i_rd_rdy,
   // Data port.
   input  camd_pkg::cmd_e            i_d_ca_cmd,
   input  wire  [`CAMD_ADDR_W-1:0]   i_d_ca_adr,
   input  wire                       i_d_ca_vld,
   output logic                      o_d_ca_rdy,
   input  wire  [`CAMD_DATA_W-1:0]   i_d_dm_dat,
   input  wire  [`CAMD_MSK_W-1:0]    i_d_dm_msk,
   input  wire                       i_d_dm_vld,
   output logic                      o_d_dm_rdy,
   output logic [`CAMD_DATA_W-1:0]   o_d_rd_dat,
   output logic                      o_d_rd_vld,
   input  wire                       i_d_rd_rdy
);

   logic [`CAMD_ADDR_W-1:0] m_adr;
   camd_pkg::cmd_e          m_cmd;
   logic [`CAMD_DATA_W-1:0] m_dat;
   logic [`CAMD_MSK_W-1:0]  m_msk;
   logic                    m_vld;
   camd_pkg::port_e         m_tag;
   logic                    m_rdy;

   logic [`CAMD_DATA_W-1:0] r_dat;
   logic                    r_vld;
   camd_pkg::port_e         r_tag;
   logic                    r_rdy;

   logic                    q_space;
   logic                    rd_push;

   // Every read that gets into the RAM takes a slot in the router.
   assign rd_push = m_vld & m_rdy & (m_cmd == camd_pkg::CMD_READ);

   camd_arbiter u_arbiter (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_i_adr    (i_i_ca_adr),
      .i_i_vld    (i_i_ca_vld),
      .o_i_rdy    (o_i_ca_rdy),
      .i_d_cmd    (i_d_ca_cmd),
      .i_d_adr    (i_d_ca_adr),
      .i_d_vld    (i_d_ca_vld),
      .o_d_rdy    (o_d_ca_rdy),
      .i_d_dat    (i_d_dm_dat),
      .i_d_msk    (i_d_dm_msk),
      .i_d_dm_vld (i_d_dm_vld),
      .o_d_dm_rdy (o_d_dm_rdy),
      .o_m_adr    (m_adr),
      .o_m_cmd    (m_cmd),
      .o_m_dat    (m_dat),
      .o_m_msk    (m_msk),
      .o_m_vld    (m_vld),
      .o_m_tag    (m_tag),
      .i_m_rdy    (m_rdy),
      .i_q_space  (q_space)
   );

   camd_ram u_ram (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_adr    (m_adr),
      .i_cmd    (m_cmd),
      .i_dat    (m_dat),
      .i_msk    (m_msk),
      .i_vld    (m_vld),
      .i_tag    (m_tag),
      .o_rdy    (m_rdy),
      .o_rd_dat (r_dat),
      .o_rd_vld (r_vld),
      .o_rd_tag (r_tag),
      .i_rd_rdy (r_rdy)
   );

   camd_resp_router u_router (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_push     (rd_push),
      .i_push_tag (m_tag),
      .o_space    (q_space),
      .i_rd_dat   (r_dat),
      .i_rd_vld   (r_vld),
      .i_rd_tag   (r_tag),
      .o_rd_rdy   (r_rdy),
      .o_i_rd_dat (o_i_rd_dat),
      .o_i_rd_vld (o_i_rd_vld),
      .i_i_rd_rdy (i_i_rd_rdy),
      .o_d_rd_dat (o_d_rd_dat),
      .o_d_rd_vld (o_d_rd_vld),
      .i_d_rd_rdy (i_d_rd_rdy)
   );

endmodule

`default_nettype wire
